/* Makefile */
SIM      ?= verilator
TOP      := ex_stage_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
COMMON   := --timing --assert --timescale 1ns/10ps
SIMFLAGS := --binary -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(SIM) --lint-only $(COMMON) --top-module $(TOP) -f $(FILELIST)

# Build and run, exit status is nonzero on any failure
sim:
	$(SIM) $(COMMON) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/ex_alu.sv */
`timescale 1ns/10ps

module ex_alu (
  input  ex_types_pkg::alu_op_e         op_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   b_i,
  output logic [ex_cfg_pkg::XLEN-1:0]   result_o
);

  import ex_cfg_pkg::*;
  import ex_types_pkg::*;

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            borrow;
  logic            lt_s;
  logic            lt_u;
  logic            eq;

  // Adder for ADD
  assign sum = a_i + b_i;

  // One subtractor serves SUB and all compares
  // Borrow out of the widened subtract is the unsigned less-than
  assign {borrow, diff} = {1'b0, a_i} - {1'b0, b_i};
  assign lt_u = borrow;

  // Signed less-than
  // Differing signs decide directly, equal signs use the difference sign
  assign lt_s = (a_i[XLEN-1] != b_i[XLEN-1]) ? a_i[XLEN-1] : diff[XLEN-1];
  assign eq   = (diff == '0);

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      // Compares give 0 or 1
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_EQ:   result_o = {{(XLEN-1){1'b0}}, eq};
      default:  result_o = '0;
    endcase
  end

endmodule

/* design/ex_apu_port.sv */
`timescale 1ns/10ps

module ex_apu_port (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                start_i,
  input  ex_types_pkg::apu_req_t              req_payload_i,
  input  logic [ex_cfg_pkg::REG_ADDR_W-1:0]   waddr_i,
  output logic                                can_start_o,
  output logic                                apu_req_o,
  output ex_types_pkg::apu_req_t              apu_req_payload_o,
  input  logic                                apu_gnt_i,
  input  logic                                apu_rvalid_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]         apu_result_i,
  output ex_types_pkg::rf_write_t             wb_o,
  input  logic                                wb_ready_i
);

  import ex_cfg_pkg::*;
  import ex_types_pkg::*;

  logic                  req_in_ready;
  logic                  awaiting_q;
  logic [REG_ADDR_W-1:0] waddr_q;
  rf_write_t             rsp_in;
  logic                  rsp_in_valid;
  logic                  rsp_in_ready;
  logic                  rsp_valid;
  rf_write_t             rsp_data;

  //////////////////////////////////////////////////////////////////////
  // Request side, buffer output drives req until gnt
  //////////////////////////////////////////////////////////////////////

  ex_hold_reg #(.payload_t(apu_req_t)) u_req_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (start_i),
    .in_ready_o  (req_in_ready),
    .in_data_i   (req_payload_i),
    .out_valid_o (apu_req_o),
    .out_ready_i (apu_gnt_i),
    .out_data_o  (apu_req_payload_o)
  );

  // Granted request now waits for rvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awaiting_q <= 1'b0;
    end else if (apu_req_o && apu_gnt_i) begin
      awaiting_q <= 1'b1;
    end else if (apu_rvalid_i) begin
      awaiting_q <= 1'b0;
    end
  end

  // Destination of the single operation in flight
  always_ff @(posedge clk) begin
    if (start_i) begin
      waddr_q <= waddr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response side, drained by write-back
  //////////////////////////////////////////////////////////////////////

  assign rsp_in_valid = apu_rvalid_i & awaiting_q;
  assign rsp_in       = '{we: 1'b1, waddr: waddr_q, wdata: apu_result_i};

  ex_hold_reg #(.payload_t(rf_write_t)) u_rsp_buf (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (rsp_in_valid),
    .in_ready_o  (rsp_in_ready),
    .in_data_i   (rsp_in),
    .out_valid_o (rsp_valid),
    .out_ready_i (wb_ready_i),
    .out_data_o  (rsp_data)
  );

  // Write enable only while an entry is held
  assign wb_o = rsp_valid ? rsp_data : '0;

  // Idle only with nothing queued, awaited or unretired
  assign can_start_o = ~apu_req_o & ~awaiting_q & ~rsp_valid;

  a_req_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    apu_req_o && !apu_gnt_i |=> apu_req_o)
    else $error("accelerator request withdrawn before grant");

  // Response only for a granted request, never into a full buffer
  a_rvalid_awaited: assert property (@(posedge clk) disable iff (!rst_n)
    apu_rvalid_i |-> awaiting_q && rsp_in_ready)
    else $error("unexpected accelerator response");

  // Top level only starts when the request buffer can take it
  a_start_room: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> req_in_ready)
    else $error("accelerator start with request buffer full");

endmodule

/* design/ex_cfg_pkg.sv */
package ex_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Register and operand width
  localparam int unsigned XLEN = 32;
  // Register file address width
  localparam int unsigned REG_ADDR_W = 5;

  //////////////////////////////////////////////////////////////////////
  // Multiplier and accelerator
  //////////////////////////////////////////////////////////////////////

  // Multiplier bits consumed per iteration
  localparam int unsigned MUL_BITS_PER_CYCLE = 2;
  // Cycles from start to done
  localparam int unsigned MUL_CYCLES = XLEN / MUL_BITS_PER_CYCLE;
  // Iteration counter width
  localparam int unsigned MUL_CNT_W = $clog2(MUL_CYCLES);
  // Accelerator opcode width and operand count
  localparam int unsigned APU_OP_W = 4;
  localparam int unsigned APU_NARGS = 2;

endpackage

/* design/ex_hold_reg.sv */
`timescale 1ns/10ps

module ex_hold_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;
  logic     load;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready_o = ~full_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  // Stalled entry keeps valid and payload
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("held entry changed under back-pressure");

endmodule

/* design/ex_mult.sv */
`timescale 1ns/10ps

module ex_mult (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   b_i,
  output logic                          busy_o,
  output logic                          done_o,
  output logic [ex_cfg_pkg::XLEN-1:0]   product_o
);

  import ex_cfg_pkg::*;

  logic                 active_q;
  logic [MUL_CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]      mcand_q;
  logic [XLEN-1:0]      mplier_q;
  logic [XLEN-1:0]      acc_q;
  logic [XLEN-1:0]      acc_next;
  logic                 last_step;

  // Shifted conditional adds for the low multiplier bits of this step
  always_comb begin
    acc_next = acc_q;
    for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
      if (mplier_q[i]) begin
        acc_next = acc_next + (mcand_q << i);
      end
    end
  end

  // Final step is added combinationally, product shows in that cycle
  assign last_step = active_q && (cnt_q == MUL_CNT_W'(MUL_CYCLES - 1));
  assign busy_o    = active_q & ~last_step;
  assign done_o    = last_step;
  assign product_o = acc_next;

  //////////////////////////////////////////////////////////////////////
  // Iteration control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (last_step) begin
        active_q <= 1'b0;
      end
    end
  end

  // Operand shifters and accumulator
  always_ff @(posedge clk) begin
    if (start_i) begin
      mcand_q  <= a_i;
      mplier_q <= b_i;
      acc_q    <= '0;
    end else if (active_q) begin
      mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
      mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
      acc_q    <= acc_next;
    end
  end

  // Issue logic must hold off while an iteration runs
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> !busy_o)
    else $error("multiply started while busy");

  // Fixed latency seen by the forwarding mux
  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> ##MUL_CYCLES done_o)
    else $error("multiply done not at fixed latency");

endmodule

/* design/ex_stage_top.sv */
`timescale 1ns/10ps

module ex_stage_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          issue_valid_i,
  input  ex_types_pkg::ex_issue_t       issue_i,
  output logic                          ex_ready_o,
  output ex_types_pkg::rf_write_t       fw_o,
  output ex_types_pkg::rf_write_t       wb_o,
  input  logic                          wb_ready_i,
  output logic                          apu_req_o,
  output ex_types_pkg::apu_req_t        apu_req_payload_o,
  input  logic                          apu_gnt_i,
  input  logic                          apu_rvalid_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   apu_result_i
);

  import ex_cfg_pkg::*;
  import ex_types_pkg::*;

  logic                  accept;
  logic                  alu_go;
  logic                  mul_start;
  logic                  apu_start;
  logic [XLEN-1:0]       alu_result;
  logic [XLEN-1:0]       mul_product;
  logic                  mul_busy;
  logic                  mul_done;
  logic                  apu_can_start;
  apu_req_t              apu_payload;
  logic [REG_ADDR_W-1:0] mul_waddr_q;
  logic                  mul_we_q;

  // Stall on a running multiply; accelerator ops also need an idle port
  assign ex_ready_o = ~mul_busy & ((issue_i.unit != UNIT_APU) | apu_can_start);
  assign accept     = issue_valid_i & ex_ready_o;

  // Unit steering
  assign alu_go    = accept & (issue_i.unit == UNIT_ALU);
  assign mul_start = accept & (issue_i.unit == UNIT_MUL);
  assign apu_start = accept & (issue_i.unit == UNIT_APU);

  assign apu_payload = '{op: issue_i.apu_op, operands: {issue_i.op_b, issue_i.op_a}};

  //////////////////////////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .op_i     (issue_i.alu_op),
    .a_i      (issue_i.op_a),
    .b_i      (issue_i.op_b),
    .result_o (alu_result)
  );

  ex_mult u_mult (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (mul_start),
    .a_i       (issue_i.op_a),
    .b_i       (issue_i.op_b),
    .busy_o    (mul_busy),
    .done_o    (mul_done),
    .product_o (mul_product)
  );

  ex_apu_port u_apu_port (
    .clk               (clk),
    .rst_n             (rst_n),
    .start_i           (apu_start),
    .req_payload_i     (apu_payload),
    .waddr_i           (issue_i.waddr),
    .can_start_o       (apu_can_start),
    .apu_req_o         (apu_req_o),
    .apu_req_payload_o (apu_req_payload_o),
    .apu_gnt_i         (apu_gnt_i),
    .apu_rvalid_i      (apu_rvalid_i),
    .apu_result_i      (apu_result_i),
    .wb_o              (wb_o),
    .wb_ready_i        (wb_ready_i)
  );

  // Multiply destination kept for the whole iteration
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mul_we_q <= 1'b0;
    end else if (mul_start) begin
      mul_we_q <= issue_i.we;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_start) begin
      mul_waddr_q <= issue_i.waddr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Forwarding port, multiply result wins over the ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_o = '0;
    if (mul_done) begin
      fw_o = '{we: mul_we_q, waddr: mul_waddr_q, wdata: mul_product};
    end else if (alu_go) begin
      fw_o = '{we: issue_i.we, waddr: issue_i.waddr, wdata: alu_result};
    end
  end

  // Decode must not send a writing ALU op in the multiply done cycle
  a_fw_no_clash: assert property (@(posedge clk) disable iff (!rst_n)
    mul_done |-> !(alu_go && issue_i.we))
    else $error("ALU write collides with multiply result");

endmodule

/* design/ex_types_pkg.sv */
package ex_types_pkg;

  import ex_cfg_pkg::*;

  // Unit an issued operation is steered to
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_APU = 2'd2
  } unit_e;

  // ALU function select
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLT  = 3'd5,
    ALU_SLTU = 3'd6,
    ALU_EQ   = 3'd7
  } alu_op_e;

  // One operation handed over by decode
  typedef struct packed {
    unit_e                 unit;
    alu_op_e               alu_op;
    logic [APU_OP_W-1:0]   apu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
  } ex_issue_t;

  // Register file write, used by forwarding and write-back ports
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_write_t;

  // Accelerator request, operand 0 in the low slot
  typedef struct packed {
    logic [APU_OP_W-1:0]                op;
    logic [APU_NARGS-1:0][XLEN-1:0]     operands;
  } apu_req_t;

endpackage

/* test/ex_stage_tb.sv */
`timescale 1ns/10ps

module ex_stage_tb;

  import ex_cfg_pkg::*;
  import ex_types_pkg::*;

  // Cycle bound with wide margin over the test length
  localparam int TIMEOUT_CYCLES = 3000;

  // Edge operand pairs for the ALU
  localparam logic [31:0] EDGE_A [5] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                         32'h7fff_ffff, 32'hffff_ffff};
  localparam logic [31:0] EDGE_B [5] = '{32'h0, 32'h0000_0001, 32'h7fff_ffff,
                                         32'h8000_0000, 32'hffff_ffff};

  logic                  clk;
  logic                  rst_n;
  logic                  issue_valid;
  ex_issue_t             issue;
  logic                  ex_ready;
  rf_write_t             fw;
  rf_write_t             wb;
  logic                  wb_ready;
  logic                  apu_req;
  apu_req_t              apu_req_payload;
  logic                  apu_gnt;
  logic                  apu_rvalid;
  logic [XLEN-1:0]       apu_result;
  logic [31:0]           lfsr_state = 32'h4aa7_6f2e;
  int                    cycle_count = 0;
  apu_req_t              exp_payload;
  logic [REG_ADDR_W-1:0] apu_waddr;

  tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(10)) u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid_i     (issue_valid),
    .issue_i           (issue),
    .ex_ready_o        (ex_ready),
    .fw_o              (fw),
    .wb_o              (wb),
    .wb_ready_i        (wb_ready),
    .apu_req_o         (apu_req),
    .apu_req_payload_o (apu_req_payload),
    .apu_gnt_i         (apu_gnt),
    .apu_rvalid_i      (apu_rvalid),
    .apu_result_i      (apu_result)
  );

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checker, random source and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    next_rand_bit = lfsr_state[31];
    lfsr_state = {lfsr_state[30:0], fb};
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_rand_bit()};
    end
    return v;
  endfunction

  // Integer rules of the ALU where compares give 0 or 1
  function automatic logic [XLEN-1:0] alu_expect(input alu_op_e op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_EQ:   return (a == b) ? 32'd1 : 32'd0;
      default:  return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Operation drivers
  //////////////////////////////////////////////////////////////////////

  // ALU result shows on the forwarding port in the accept cycle
  task automatic run_alu_op(input alu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
    rf_write_t             exp;
    logic [REG_ADDR_W-1:0] wa;
    logic                  we;
    wa  = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    we  = 1'(rand_bits(1));
    exp = '{we: we, waddr: wa, wdata: alu_expect(op, a, b)};
    @(negedge clk);
    issue_valid = 1'b1;
    issue = '{unit: UNIT_ALU, alu_op: op, apu_op: '0, op_a: a, op_b: b, waddr: wa, we: we};
    #1;
    check_equal(128'(ex_ready), 128'(1'b1), "ready for ALU op");
    check_equal(128'(fw), 128'(exp), "ALU forward write");
    @(negedge clk);
    issue_valid = 1'b0;
    issue = '0;
  endtask

  // Stall for the iteration and product on the port in the last cycle
  task automatic multiply_and_check(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    rf_write_t             exp;
    logic [REG_ADDR_W-1:0] wa;
    logic                  we;
    wa  = REG_ADDR_W'(rand_bits(REG_ADDR_W));
    we  = 1'(rand_bits(1));
    exp = '{we: we, waddr: wa, wdata: a * b};
    @(negedge clk);
    issue_valid = 1'b1;
    issue = '{unit: UNIT_MUL, alu_op: ALU_ADD, apu_op: '0, op_a: a, op_b: b, waddr: wa, we: we};
    #1;
    check_equal(128'(ex_ready), 128'(1'b1), "ready for multiply");
    check_equal(128'(fw.we), 128'(1'b0), "no forward write at multiply accept");
    for (int k = 1; k <= MUL_CYCLES; k++) begin
      @(negedge clk);
      issue_valid = 1'b0;
      issue = '0;
      #1;
      if (k < MUL_CYCLES) begin
        check_equal(128'(ex_ready), 128'(1'b0), "stall during multiply");
        check_equal(128'(fw.we), 128'(1'b0), "no forward write during multiply");
      end else begin
        check_equal(128'(ex_ready), 128'(1'b1), "ready in multiply done cycle");
        check_equal(128'(fw), 128'(exp), "multiply forward write");
      end
    end
  endtask

  // Issue an accelerator op and see the request rise
  task automatic launch_apu(input logic [APU_OP_W-1:0] op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [REG_ADDR_W-1:0] wa);
    exp_payload.op          = op;
    exp_payload.operands[0] = a;
    exp_payload.operands[1] = b;
    apu_waddr               = wa;
    @(negedge clk);
    issue_valid = 1'b1;
    issue = '{unit: UNIT_APU, alu_op: ALU_ADD, apu_op: op, op_a: a, op_b: b, waddr: wa, we: 1'b1};
    #1;
    check_equal(128'(ex_ready), 128'(1'b1), "ready for accelerator op");
    check_equal(128'(fw.we), 128'(1'b0), "no forward write for accelerator op");
    @(negedge clk);
    issue_valid = 1'b0;
    issue = '0;
    #1;
    check_equal(128'(apu_req), 128'(1'b1), "request raised");
    check_equal(128'(apu_req_payload), 128'(exp_payload), "request payload");
  endtask

  // Accelerator side grants and then answers after the given delays
  task automatic serve_accelerator(input int gnt_delay, input int rsp_delay,
                                   input logic [XLEN-1:0] result);
    repeat (gnt_delay) begin
      @(negedge clk);
      #1;
      check_equal(128'(apu_req), 128'(1'b1), "request held until grant");
      check_equal(128'(apu_req_payload), 128'(exp_payload), "payload stable until grant");
    end
    @(negedge clk);
    apu_gnt = 1'b1;
    #1;
    check_equal(128'(apu_req), 128'(1'b1), "request high at grant");
    @(negedge clk);
    apu_gnt = 1'b0;
    #1;
    check_equal(128'(apu_req), 128'(1'b0), "request dropped after grant");
    check_equal(128'(wb.we), 128'(1'b0), "no write-back before response");
    repeat (rsp_delay) begin
      @(negedge clk);
      #1;
      check_equal(128'(wb.we), 128'(1'b0), "no write-back before response");
    end
    @(negedge clk);
    apu_rvalid = 1'b1;
    apu_result = result;
    @(negedge clk);
    apu_rvalid = 1'b0;
    apu_result = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    #1;
    check_equal(128'(ex_ready), 128'(1'b1), "ready after reset");
    check_equal(128'(apu_req), 128'(1'b0), "no request after reset");
    check_equal(128'(fw.we), 128'(1'b0), "no forward write after reset");
    check_equal(128'(wb.we), 128'(1'b0), "no write-back after reset");
  endtask

  task automatic test_alu_ops();
    for (int op = 0; op < 8; op++) begin
      for (int e = 0; e < 5; e++) begin
        run_alu_op(alu_op_e'(3'(op)), EDGE_A[e], EDGE_B[e]);
      end
      repeat (4) run_alu_op(alu_op_e'(3'(op)), rand_bits(XLEN), rand_bits(XLEN));
    end
  endtask

  task automatic test_multiply();
    repeat (4) multiply_and_check(rand_bits(XLEN), rand_bits(XLEN));
    multiply_and_check(32'hffff_ffff, 32'hffff_ffff);
    // ALU op right after the multiply retires
    run_alu_op(ALU_SUB, rand_bits(XLEN), rand_bits(XLEN));
  endtask

  task automatic test_apu_roundtrip();
    logic [XLEN-1:0] res;
    repeat (5) begin
      res = rand_bits(XLEN);
      launch_apu(APU_OP_W'(rand_bits(APU_OP_W)), rand_bits(XLEN), rand_bits(XLEN),
                 REG_ADDR_W'(rand_bits(REG_ADDR_W)));
      serve_accelerator(int'(rand_bits(3)), int'(rand_bits(3)), res);
      #1;
      check_equal(128'(wb), 128'({1'b1, apu_waddr, res}), "accelerator write-back");
      @(negedge clk);
      #1;
      check_equal(128'(wb.we), 128'(1'b0), "write-back retired");
    end
  endtask

  task automatic test_wb_backpressure();
    logic [XLEN-1:0] res;
    res = rand_bits(XLEN);
    @(negedge clk);
    wb_ready = 1'b0;
    launch_apu(4'h9, rand_bits(XLEN), rand_bits(XLEN), 5'd17);
    serve_accelerator(1, 2, res);
    // Another accelerator op waits on decode without valid
    issue.unit = UNIT_APU;
    repeat (6) begin
      #1;
      check_equal(128'(wb), 128'({1'b1, apu_waddr, res}), "write-back held");
      check_equal(128'(ex_ready), 128'(1'b0), "stall under back-pressure");
      @(negedge clk);
    end
    wb_ready = 1'b1;
    #1;
    check_equal(128'(wb), 128'({1'b1, apu_waddr, res}), "write-back at release");
    @(negedge clk);
    #1;
    check_equal(128'(wb.we), 128'(1'b0), "write-back cleared");
    check_equal(128'(ex_ready), 128'(1'b1), "ready after release");
    @(negedge clk);
    issue = '0;
  endtask

  task automatic test_overlap();
    logic [XLEN-1:0] res;
    res = rand_bits(XLEN);
    launch_apu(APU_OP_W'(rand_bits(APU_OP_W)), rand_bits(XLEN), rand_bits(XLEN), 5'd3);
    repeat (3) run_alu_op(alu_op_e'(3'(rand_bits(3))), rand_bits(XLEN), rand_bits(XLEN));
    #1;
    check_equal(128'(apu_req), 128'(1'b1), "request outstanding during ALU ops");
    multiply_and_check(rand_bits(XLEN), rand_bits(XLEN));
    run_alu_op(ALU_XOR, rand_bits(XLEN), rand_bits(XLEN));
    serve_accelerator(1, 3, res);
    #1;
    check_equal(128'(wb), 128'({1'b1, apu_waddr, res}), "overlapped write-back");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    issue_valid = 1'b0;
    issue       = '0;
    wb_ready    = 1'b1;
    apu_gnt     = 1'b0;
    apu_rvalid  = 1'b0;
    apu_result  = '0;
    @(posedge rst_n);
    test_reset_state();
    test_alu_ops();
    test_multiply();
    test_apu_roundtrip();
    test_wb_backpressure();
    test_overlap();
    repeat (2) @(negedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

// Free-running clock plus power-on reset
module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* verilog.f */
design/ex_cfg_pkg.sv
design/ex_types_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_hold_reg.sv
design/ex_apu_port.sv
design/ex_stage_top.sv
test/tb_clock.sv
test/ex_stage_tb.sv
